// File: lsu_top.f
logic/lsu_pkg.sv
logic/axi_rd_if.sv
logic/axi_wr_if.sv
logic/bank_wr_if.sv
logic/dmem_bank.sv
logic/dmem_read_port.sv
logic/dmem_write_port.sv
logic/lsu.sv
logic/lsu_top.sv
verif/lsu_props.sv
verif/lsu_checker.sv
verif/lsu_tb.sv

// File: verif/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        logic    load;
        logic    store;
        mem_op_t op;
        addr_t   addr;
        word_t   wdata;
        word_t   exp_data;
        logic    exp_err;
    } entry_t;

    logic        clock;
    logic        reset;
    logic        req_valid;
    logic        req_ready;
    logic        req_load;
    logic        req_store;
    mem_op_t     req_op;
    addr_t       req_addr;
    word_t       req_wdata;
    logic        rsp_valid;
    logic        rsp_ready;
    word_t       rsp_data;
    logic        rsp_err;
    logic        push;
    word_t       exp_data;
    logic        exp_err;
    int          checked;
    int          errors;
    int          pending;
    int          cycles;
    int          limit;
    int          results_due;
    logic [31:0] rng;
    logic [7:0]  mem_model [0:4*MEM_WORDS-1];   // byte view of the bank
    entry_t      table_q[$];

    lsu_top #(.MEM_WORDS(MEM_WORDS)) UUT (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_load  (req_load),
        .req_store (req_store),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err)
    );

    lsu_checker u_checker (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err),
        .push      (push),
        .exp_data  (exp_data),
        .exp_err   (exp_err),
        .checked   (checked),
        .errors    (errors),
        .pending   (pending)
    );

    bind lsu lsu_props u_props (
        .clock     (clock),
        .reset     (reset),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .arvalid   (rd.arvalid),
        .awvalid   (wr.awvalid),
        .wvalid    (wr.wvalid),
        .wstrb     (wr.wstrb)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // halfwords look at bit 1 only, words at neither low bit
    function automatic word_t predict_load(input mem_op_t op, input addr_t addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[9:0];
        b = mem_model[a];
        h = {mem_model[{a[9:1], 1'b1}], mem_model[{a[9:1], 1'b0}]};
        case (op)
            OP_B:    return {{24{b[7]}}, b};
            OP_BU:   return {24'h0, b};
            OP_H:    return {{16{h[15]}}, h};
            OP_HU:   return {16'h0, h};
            default: return {mem_model[{a[9:2], 2'd3}], mem_model[{a[9:2], 2'd2}],
                             mem_model[{a[9:2], 2'd1}], mem_model[{a[9:2], 2'd0}]};
        endcase
    endfunction

    task automatic apply_store(input mem_op_t op, input addr_t addr, input word_t wdata);
        logic [9:0] a;
        a = addr[9:0];
        case (op)
            OP_B: mem_model[a] = wdata[7:0];
            OP_H: begin
                mem_model[{a[9:1], 1'b0}] = wdata[7:0];
                mem_model[{a[9:1], 1'b1}] = wdata[15:8];
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    mem_model[{a[9:2], 2'b00} + k] = wdata[8*k +: 8];
                end
            end
        endcase
    endtask

    task automatic append_entry(input logic load, input logic store, input mem_op_t op,
                                input addr_t addr, input word_t wdata);
        entry_t e;
        logic   out_of_range;
        out_of_range = (addr[31:2] >= MEM_WORDS);
        e = '{load, store, op, addr, wdata, 32'h0, 1'b0};
        if (load) begin
            e.exp_data = out_of_range ? 32'h0 : predict_load(op, addr);
            e.exp_err  = out_of_range;
        end else if (store) begin
            if (!out_of_range) begin
                apply_store(op, addr, wdata);
            end
            e.exp_err = out_of_range;
        end
        table_q.push_back(e);
    endtask

    task automatic fill_table();
        for (int i = 0; i < 8; i++) begin
            append_entry(1'b0, 1'b1, OP_W, i * 4, 32'h9e37_79b9 * (i + 1));
        end
        for (int i = 0; i < 8; i++) begin
            append_entry(1'b1, 1'b0, OP_W, i * 4, 32'h0);
        end
        // lane writes into words 1 and 2
        append_entry(1'b0, 1'b1, OP_B, 32'h04, 32'h0000_00c3);
        append_entry(1'b0, 1'b1, OP_B, 32'h07, 32'hffff_ff5a);
        append_entry(1'b0, 1'b0, OP_W, 32'h04, 32'h1234_5678);   // neither load nor store
        append_entry(1'b0, 1'b1, OP_H, 32'h08, 32'h0000_8001);
        append_entry(1'b0, 1'b1, OP_H, 32'h0b, 32'hdead_7ffe);
        append_entry(1'b1, 1'b0, OP_W, 32'h04, 32'h0);
        append_entry(1'b1, 1'b0, OP_W, 32'h08, 32'h0);
        // sign bits on and off in every lane
        append_entry(1'b0, 1'b1, OP_W, 32'h0c, 32'h80ff_7f01);
        append_entry(1'b0, 1'b1, OP_W, 32'h10, 32'h7f80_01ff);
        append_entry(1'b0, 1'b1, OP_W, 32'h14, 32'h8000_7fff);
        append_entry(1'b0, 1'b1, OP_W, 32'h18, 32'h7fff_8000);
        for (int i = 0; i < 4; i++) begin
            append_entry(1'b1, 1'b0, OP_B,  32'h0c + i, 32'h0);
            append_entry(1'b1, 1'b0, OP_BU, 32'h0c + i, 32'h0);
            append_entry(1'b1, 1'b0, OP_B,  32'h10 + i, 32'h0);
            append_entry(1'b1, 1'b0, OP_BU, 32'h10 + i, 32'h0);
            append_entry(1'b1, 1'b0, OP_H,  32'h14 + i, 32'h0);
            append_entry(1'b1, 1'b0, OP_HU, 32'h14 + i, 32'h0);
            append_entry(1'b1, 1'b0, OP_H,  32'h18 + i, 32'h0);
            append_entry(1'b1, 1'b0, OP_HU, 32'h18 + i, 32'h0);
        end
        append_entry(1'b1, 1'b0, OP_W, 32'h1f, 32'h0);
        // out-of-range accesses must not touch the words 0 and 255 they alias
        append_entry(1'b0, 1'b1, OP_W, 32'h0000_03fc, 32'h0bad_cafe);
        append_entry(1'b0, 1'b1, OP_W, 32'h0000_0400, 32'hbad0_bad0);
        append_entry(1'b1, 1'b0, OP_W, 32'h0000_0400, 32'h0);
        append_entry(1'b1, 1'b0, OP_B, 32'h8000_0003, 32'h0);
        append_entry(1'b0, 1'b1, OP_B, 32'hffff_fffd, 32'h0000_005a);
        append_entry(1'b1, 1'b0, OP_W, 32'h0000_0000, 32'h0);
        append_entry(1'b0, 1'b0, OP_B, 32'h0000_0000, 32'h0);
        append_entry(1'b1, 1'b0, OP_HU, 32'h0000_0002, 32'h0);
        append_entry(1'b1, 1'b0, OP_W, 32'h0000_03fc, 32'h0);
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        rng = xorshift(rng);
        rsp_ready <= rng[0];
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, %0d results still pending", cycles, pending);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        entry_t e;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_load    = 1'b0;
        req_store   = 1'b0;
        req_op      = OP_W;
        req_addr    = '0;
        req_wdata   = '0;
        rsp_ready   = 1'b0;
        push        = 1'b0;
        exp_data    = '0;
        exp_err     = 1'b0;
        rng         = 32'hf1e1;
        cycles      = 0;
        results_due = 0;
        fill_table();
        limit = table_q.size() * 20 + RESET_CYCLES + 100;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        foreach (table_q[i]) begin
            e = table_q[i];
            req_valid <= 1'b1;
            req_load  <= e.load;
            req_store <= e.store;
            req_op    <= e.op;
            req_addr  <= e.addr;
            req_wdata <= e.wdata;
            push      <= e.load || e.store;
            exp_data  <= e.exp_data;
            exp_err   <= e.exp_err;
            @(posedge clock);
            while (!req_ready) @(posedge clock);
            if (e.load || e.store) begin
                results_due++;
            end else begin
                $display("entry %0d accepted with no load or store, no result due", i);
            end
        end
        req_valid <= 1'b0;
        push      <= 1'b0;
        @(negedge clock);
        while (pending != 0) @(negedge clock);
        repeat (10) @(negedge clock);   // room for a stray extra result
        $display("%0d results checked of %0d due, %0d check errors, %0d assertion failures",
                 checked, results_due, errors, UUT.u_lsu.u_props.failures);
        if (checked != results_due) begin
            $display("result count wrong: %0d due, %0d received", results_due, checked);
        end
        if (errors == 0 && checked == results_due && UUT.u_lsu.u_props.failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/lsu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_checker (
    input  wire logic           clock,
    input  wire logic           reset,
    input  wire logic           req_valid,
    input  wire logic           req_ready,
    input  wire logic           rsp_valid,
    input  wire logic           rsp_ready,
    input  wire lsu_pkg::word_t rsp_data,
    input  wire logic           rsp_err,
    input  wire logic           push,       // entry on the request port expects a result
    input  wire lsu_pkg::word_t exp_data,
    input  wire logic           exp_err,
    output int                  checked,
    output int                  errors,
    output int                  pending
);
    import lsu_pkg::*;

    word_t want_data_q[$];
    logic  want_err_q[$];
    word_t want_data;
    logic  want_err;
    logic  mismatch;

    initial begin
        checked = 0;
        errors  = 0;
        pending = 0;
    end

    always @(posedge clock) begin
        if (!reset) begin
            if (rsp_valid && rsp_ready) begin
                if (want_data_q.size() == 0) begin
                    $display("unexpected result at %0t with no request outstanding", $time);
                    errors++;
                end else begin
                    want_data = want_data_q.pop_front();
                    want_err  = want_err_q.pop_front();
                    mismatch  = 1'b0;
                    if (rsp_data !== want_data) begin
                        $display("** Error at %0t: rsp_data = %h, expected %h",
                                 $time, rsp_data, want_data);
                        mismatch = 1'b1;
                    end
                    if (rsp_err !== want_err) begin
                        $display("** Error at %0t: rsp_err = %b, expected %b",
                                 $time, rsp_err, want_err);
                        mismatch = 1'b1;
                    end
                    checked++;
                    if (mismatch) begin
                        errors++;
                    end
                    $display("test %0d %s: data %h err %b", checked,
                             mismatch ? "mismatch" : "ok", rsp_data, rsp_err);
                end
            end
            if (rsp_valid && !rsp_ready && req_ready) begin
                $display("request port open at %0t while a result waits", $time);
                errors++;
            end
            if (push && req_valid && req_ready) begin
                if (want_data_q.size() != 0) begin  // only one in flight
                    $display("request accepted at %0t with a result outstanding", $time);
                    errors++;
                end
                want_data_q.push_back(exp_data);
                want_err_q.push_back(exp_err);
            end
            pending = want_data_q.size();
        end
    end

endmodule

`default_nettype wire

// File: verif/lsu_props.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_props (
    input wire logic           clock,
    input wire logic           reset,
    input wire logic           rsp_valid,
    input wire logic           rsp_ready,
    input wire lsu_pkg::word_t rsp_data,
    input wire logic           arvalid,
    input wire logic           awvalid,
    input wire logic           wvalid,
    input wire lsu_pkg::strb_t wstrb
);
    int failures = 0;

    rsp_hold: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
        $error("result dropped or changed before rsp_ready");
        failures++;
    end

    one_addr_channel: assert property (@(posedge clock) disable iff (reset)
        !(arvalid && awvalid))
    else begin
        $error("arvalid and awvalid high together");
        failures++;
    end

    strobe_set: assert property (@(posedge clock) disable iff (reset)
        wvalid |-> wstrb != 4'b0000)
    else begin
        $error("write beat with empty strobe");
        failures++;
    end

    // nothing valid straight out of reset
    reset_clear: assert property (@(posedge clock) reset |=> !rsp_valid)
    else begin
        $error("rsp_valid high in the cycle after reset");
        failures++;
    end

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic             clock,
    input  wire logic             reset,

    input  wire logic             req_valid,
    output      logic             req_ready,
    input  wire logic             req_load,
    input  wire logic             req_store,
    input  wire lsu_pkg::mem_op_t req_op,
    input  wire lsu_pkg::addr_t   req_addr,
    input  wire lsu_pkg::word_t   req_wdata,

    output      logic             rsp_valid,
    input  wire logic             rsp_ready,
    output      lsu_pkg::word_t   rsp_data,
    output      logic             rsp_err
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    axi_rd_if                 rd ();
    axi_wr_if                 wr ();
    bank_wr_if #(.IDX_W(IDX_W)) bank_wr ();

    logic [IDX_W-1:0] bank_rindex;
    word_t            bank_rdata;

    lsu u_lsu (
        .clock     (clock),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_load  (req_load),
        .req_store (req_store),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .rsp_err   (rsp_err),
        .rd        (rd.manager),
        .wr        (wr.manager)
    );

    dmem_read_port #(.MEM_WORDS(MEM_WORDS)) u_rd_port (
        .clock       (clock),
        .reset       (reset),
        .bank_rindex (bank_rindex),
        .bank_rdata  (bank_rdata),
        .rd          (rd.subordinate)
    );

    dmem_write_port #(.MEM_WORDS(MEM_WORDS)) u_wr_port (
        .clock (clock),
        .reset (reset),
        .wr    (wr.subordinate),
        .bank  (bank_wr.source)
    );

    dmem_bank #(.MEM_WORDS(MEM_WORDS)) u_bank (
        .clock  (clock),
        .rindex (bank_rindex),
        .rdata  (bank_rdata),
        .bank   (bank_wr.sink)
    );

endmodule

`default_nettype wire

// File: logic/lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu (
    input  wire logic            clock,
    input  wire logic            reset,

    input  wire logic            req_valid,
    output      logic            req_ready,
    input  wire logic            req_load,
    input  wire logic            req_store,
    input  wire lsu_pkg::mem_op_t req_op,
    input  wire lsu_pkg::addr_t  req_addr,
    input  wire lsu_pkg::word_t  req_wdata,

    output      logic            rsp_valid,
    input  wire logic            rsp_ready,
    output      lsu_pkg::word_t  rsp_data,
    output      logic            rsp_err,

    axi_rd_if.manager            rd,
    axi_wr_if.manager            wr
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_AR,
        ST_WAIT_R,
        ST_WAIT_AW,
        ST_WAIT_W,
        ST_WAIT_B,
        ST_RESULT
    } state_t;

    state_t  state;

    // latched request
    addr_t   addr_q;
    mem_op_t op_q;
    logic [1:0] off_q;
    word_t   wdata_q;
    strb_t   strb_q;

    // result buffer
    word_t   rdata_q;
    logic    err_q;

    logic    req_fire;
    logic    ar_fire;
    logic    r_fire;
    logic    aw_fire;
    logic    w_fire;
    logic    b_fire;
    logic    rsp_fire;

    logic [1:0] req_off;
    strb_t   req_strb;

    assign req_ready = (state == ST_IDLE) || (state == ST_RESULT && rsp_ready);
    assign rsp_valid = (state == ST_RESULT);

    assign req_fire = req_valid && req_ready;
    assign rsp_fire = rsp_valid && rsp_ready;
    assign ar_fire  = rd.arvalid && rd.arready;
    assign r_fire   = rd.rvalid && rd.rready;
    assign aw_fire  = wr.awvalid && wr.awready;
    assign w_fire   = wr.wvalid && wr.wready;
    assign b_fire   = wr.bvalid && wr.bready;

    // halfwords see bit 1 only and words no offset
    always_comb begin
        case (req_op)
            OP_B, OP_BU: req_off = req_addr[1:0];
            OP_H, OP_HU: req_off = {req_addr[1], 1'b0};
            default:     req_off = 2'b00;
        endcase
    end

    always_comb begin
        case (req_op)
            OP_B:    req_strb = 4'b0001 << req_addr[1:0];
            OP_H:    req_strb = 4'b0011 << {req_addr[1], 1'b0};
            OP_W:    req_strb = 4'b1111;
            default: req_strb = 4'b0000;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE, ST_RESULT: begin
                    if (req_fire && req_load) begin
                        state <= ST_WAIT_AR;
                    end else if (req_fire && req_store) begin
                        state <= ST_WAIT_AW;
                    end else if (state == ST_RESULT && rsp_fire) begin
                        state <= ST_IDLE;   // also drops an empty request
                    end
                end
                ST_WAIT_AR: if (ar_fire) state <= ST_WAIT_R;
                ST_WAIT_R:  if (r_fire)  state <= ST_RESULT;
                ST_WAIT_AW: if (aw_fire) state <= ST_WAIT_W;
                ST_WAIT_W:  if (w_fire)  state <= ST_WAIT_B;
                ST_WAIT_B:  if (b_fire)  state <= ST_RESULT;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q  <= req_addr;
            op_q    <= req_op;
            off_q   <= req_off;
            wdata_q <= req_wdata << {req_off, 3'b000};
            strb_q  <= req_strb;
        end
    end

    always_ff @(posedge clock) begin
        if (r_fire) begin
            rdata_q <= rd.rdata >> {off_q, 3'b000};
            err_q   <= (rd.rresp != RESP_OKAY);
        end else if (b_fire) begin
            rdata_q <= '0;  // stores return zero
            err_q   <= (wr.bresp != RESP_OKAY);
        end
    end

    always_comb begin
        case (op_q)
            OP_B:    rsp_data = {{24{rdata_q[7]}}, rdata_q[7:0]};
            OP_H:    rsp_data = {{16{rdata_q[15]}}, rdata_q[15:0]};
            OP_W:    rsp_data = rdata_q;
            OP_BU:   rsp_data = {24'b0, rdata_q[7:0]};
            OP_HU:   rsp_data = {16'b0, rdata_q[15:0]};
            default: rsp_data = '0;
        endcase
    end

    assign rsp_err = err_q;

    assign rd.arvalid = (state == ST_WAIT_AR);
    assign rd.araddr  = addr_q;
    assign rd.rready  = (state == ST_WAIT_R);

    assign wr.awvalid = (state == ST_WAIT_AW);
    assign wr.awaddr  = addr_q;
    assign wr.wvalid  = (state == ST_WAIT_W);   // only after AW
    assign wr.wdata   = wdata_q;
    assign wr.wstrb   = strb_q;
    assign wr.bready  = (state == ST_WAIT_B);

endmodule

`default_nettype wire

// File: logic/dmem_write_port.sv
`timescale 1ns/100ps
`default_nettype none

module dmem_write_port #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic     clock,
    input  wire logic     reset,
    axi_wr_if.subordinate wr,
    bank_wr_if.source     bank
);
    import lsu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        WP_IDLE,
        WP_DATA,    // address held until the W beat
        WP_RESP
    } wp_state_t;

    wp_state_t        state;
    logic [IDX_W-1:0] index_q;
    logic             in_range_q;
    logic             aw_fire;
    logic             w_fire;
    logic             b_fire;

    assign wr.awready = (state == WP_IDLE);
    assign wr.wready  = (state == WP_DATA);
    assign wr.bvalid  = (state == WP_RESP);
    assign wr.bresp   = in_range_q ? RESP_OKAY : RESP_SLVERR;

    assign aw_fire = wr.awvalid && wr.awready;
    assign w_fire  = wr.wvalid && wr.wready;
    assign b_fire  = wr.bvalid && wr.bready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= WP_IDLE;
        end else begin
            case (state)
                WP_IDLE: if (aw_fire) state <= WP_DATA;
                WP_DATA: if (w_fire)  state <= WP_RESP;
                WP_RESP: if (b_fire)  state <= WP_IDLE;
                default: state <= WP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire) begin
            index_q    <= wr.awaddr[IDX_W+1:2];
            in_range_q <= (wr.awaddr[31:2] < MEM_WORDS);
        end
    end

    // out-of-range writes never reach the bank
    assign bank.we     = w_fire && in_range_q;
    assign bank.windex = index_q;
    assign bank.wdata  = wr.wdata;
    assign bank.wstrb  = wr.wstrb;

endmodule

`default_nettype wire

// File: logic/dmem_read_port.sv
`timescale 1ns/100ps
`default_nettype none

module dmem_read_port #(
    parameter int MEM_WORDS = 256,
    localparam int IDX_W = $clog2(MEM_WORDS)
) (
    input  wire logic           clock,
    input  wire logic           reset,
    output      logic [IDX_W-1:0] bank_rindex,
    input  wire lsu_pkg::word_t bank_rdata,
    axi_rd_if.subordinate       rd
);
    import lsu_pkg::*;

    logic pend;         // bank read in progress
    logic in_range;
    logic in_range_q;
    logic ar_fire;

    assign ar_fire     = rd.arvalid && rd.arready;
    assign rd.arready  = !pend && !rd.rvalid;
    assign in_range    = (rd.araddr[31:2] < MEM_WORDS);
    assign bank_rindex = rd.araddr[IDX_W+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            pend     <= 1'b0;
            rd.rvalid <= 1'b0;
        end else if (ar_fire) begin
            pend <= 1'b1;
        end else if (pend) begin
            pend      <= 1'b0;
            rd.rvalid <= 1'b1;
        end else if (rd.rvalid && rd.rready) begin
            rd.rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            in_range_q <= in_range;
        end
        if (pend) begin
            rd.rdata <= in_range_q ? bank_rdata : '0;
            rd.rresp <= in_range_q ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

// File: logic/dmem_bank.sv
`timescale 1ns/100ps
`default_nettype none

module dmem_bank #(
    parameter int MEM_WORDS = 256,
    localparam int IDX_W = $clog2(MEM_WORDS)
) (
    input  wire logic             clock,
    input  wire logic [IDX_W-1:0] rindex,
    output      lsu_pkg::word_t   rdata,
    bank_wr_if.sink               bank
);
    import lsu_pkg::*;

    word_t mem [MEM_WORDS];

    always_ff @(posedge clock) begin
        rdata <= mem[rindex];   // one cycle read
    end

    always_ff @(posedge clock) begin
        if (bank.we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bank.wstrb[lane]) begin
                    mem[bank.windex][lane*8 +: 8] <= bank.wdata[lane*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/bank_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface bank_wr_if #(
    parameter int IDX_W = 8
);
    import lsu_pkg::*;

    logic             we;     // single-cycle pulse
    logic [IDX_W-1:0] windex;
    word_t            wdata;
    strb_t            wstrb;

    modport source (output we, windex, wdata, wstrb);
    modport sink   (input  we, windex, wdata, wstrb);

endinterface

`default_nettype wire

// File: logic/axi_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axi_wr_if;
    import lsu_pkg::*;

    // write address
    logic  awvalid;
    logic  awready;
    addr_t awaddr;

    // write data
    logic  wvalid;
    logic  wready;
    word_t wdata;
    strb_t wstrb;

    // write response
    logic  bvalid;
    logic  bready;
    resp_t bresp;

    modport manager (
        output awvalid, awaddr,
        output wvalid, wdata, wstrb,
        output bready,
        input  awready, wready, bvalid, bresp
    );

    modport subordinate (
        input  awvalid, awaddr,
        input  wvalid, wdata, wstrb,
        input  bready,
        output awready, wready, bvalid, bresp
    );

endinterface

`default_nettype wire

// File: logic/axi_rd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axi_rd_if;
    import lsu_pkg::*;

    logic  arvalid;
    logic  arready;
    addr_t araddr;

    logic  rvalid;
    logic  rready;
    word_t rdata;
    resp_t rresp;

    modport manager (
        output arvalid, araddr, rready,
        input  arready, rvalid, rdata, rresp
    );

    modport subordinate (
        input  arvalid, araddr, rready,
        output arready, rvalid, rdata, rresp
    );

endinterface

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;
    typedef logic [2:0]  mem_op_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // funct3 of loads and stores
    localparam mem_op_t OP_B  = 3'b000;
    localparam mem_op_t OP_H  = 3'b001;
    localparam mem_op_t OP_W  = 3'b010;
    localparam mem_op_t OP_BU = 3'b100;
    localparam mem_op_t OP_HU = 3'b101;

endpackage

`default_nettype wire
